//--- all.f
logic/character_pkg.sv
logic/button_sampler.sv
logic/motion_fsm.sv
logic/physics_integrator.sv
logic/contact_detector.sv
logic/character_top.sv
sim/tb_clock_gen.sv
sim/tb_character.sv

//--- logic/button_sampler.sv
`timescale 1ns/10ps
`default_nettype none

module button_sampler (
    input  wire                          sys_clk,
    input  wire                          sys_rst_n,
    input  wire                          left_btn,
    input  wire                          right_btn,
    input  wire                          jump_btn,
    input  wire                          on_ground,
    input  wire character_pkg::motion_state_t motion_state,
    output logic                         left_held,
    output logic                         right_held,
    output logic                         jump_held,
    output logic                         jump_request
);

    import character_pkg::*;

    logic jump_rise;

    // ------------------------------------------------------------------
    // raw button registers
    // ------------------------------------------------------------------

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_held  <= 1'b0;
            right_held <= 1'b0;
            jump_held  <= 1'b0;
        end else begin
            left_held  <= left_btn;
            right_held <= right_btn;
            jump_held  <= jump_btn;
        end
    end

    assign jump_rise = jump_btn && !jump_held;  // raw high, last sample low

    // ------------------------------------------------------------------
    // sticky jump request
    // ------------------------------------------------------------------

    // a press between two ticks is held here until the FSM launches
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_request <= 1'b0;
        end else if (motion_state == JUMP) begin
            jump_request <= 1'b0;  // consumed by the launch
        end else if (jump_rise && on_ground) begin
            jump_request <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/character_pkg.sv
`default_nettype none

package character_pkg;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    // pixel positions, and velocities in 1/512 pixel units
    typedef logic signed [16:0] phys_t;

    // jump charge count
    typedef logic [15:0] charge_t;

    // +1 facing increasing x, -1 facing decreasing x
    typedef logic signed [1:0] face_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LEFT   = 3'd1,  // walking toward larger x
        RIGHT  = 3'd2,  // walking toward smaller x
        CHARGE = 3'd3,
        JUMP   = 3'd4   // single launch tick
    } motion_state_t;

    // ------------------------------------------------------------------
    // fixed point and geometry
    // ------------------------------------------------------------------

    localparam int SUBPIXEL_SHIFT = 9;  // fraction bits of a velocity

    localparam phys_t FLOOR_Y   = 17'sd20;
    localparam phys_t MIN_POS_X = 17'sd160;  // inner face of the low-x wall
    localparam phys_t MAX_POS_X = 17'sd528;  // inner face of the high-x wall

    localparam phys_t START_POS_X = 17'sd240;
    localparam phys_t START_POS_Y = 17'sd20;

    // ------------------------------------------------------------------
    // physics
    // ------------------------------------------------------------------

    localparam phys_t WALK_STEP = 17'sd3;     // pixels per tick
    localparam phys_t GRAVITY   = 17'sd512;   // one pixel per tick per tick
    localparam phys_t MAX_VEL   = 17'sd20480; // 40 pixels per tick

    // launch velocity before the charge bonus
    localparam phys_t JUMP_BASE_VX = 17'sd1024;
    localparam phys_t JUMP_BASE_VY = 17'sd3072;

    localparam charge_t CHARGE_STEP = 16'd10;
    localparam charge_t MAX_CHARGE  = 16'd500;

endpackage

`default_nettype wire

//--- logic/character_top.sv
`timescale 1ns/10ps
`default_nettype none

module character_top (
    input  wire                          sys_clk,
    input  wire                          sys_rst_n,
    input  wire                          step_tick,
    input  wire                          left_btn,
    input  wire                          right_btn,
    input  wire                          jump_btn,
    output character_pkg::phys_t         pos_x,
    output character_pkg::phys_t         pos_y,
    output character_pkg::face_t         face,
    output character_pkg::motion_state_t motion_state,
    output logic                         on_ground
);

    import character_pkg::*;

    logic    left_held;
    logic    right_held;
    logic    jump_held;
    logic    jump_request;
    logic    wall_hit;
    charge_t charge;
    phys_t   vel_x;
    phys_t   vel_y;

    // ------------------------------------------------------------------
    // buttons and FSM
    // ------------------------------------------------------------------

    button_sampler u_buttons (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .left_btn     (left_btn),
        .right_btn    (right_btn),
        .jump_btn     (jump_btn),
        .on_ground    (on_ground),
        .motion_state (motion_state),
        .left_held    (left_held),
        .right_held   (right_held),
        .jump_held    (jump_held),
        .jump_request (jump_request)
    );

    motion_fsm u_fsm (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .step_tick    (step_tick),
        .left_held    (left_held),
        .right_held   (right_held),
        .jump_held    (jump_held),
        .jump_request (jump_request),
        .on_ground    (on_ground),
        .wall_hit     (wall_hit),
        .motion_state (motion_state),
        .face         (face),
        .charge       (charge)
    );

    // ------------------------------------------------------------------
    // movement and contact loop
    // ------------------------------------------------------------------

    physics_integrator u_physics (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .step_tick    (step_tick),
        .motion_state (motion_state),
        .face         (face),
        .charge       (charge),
        .on_ground    (on_ground),
        .wall_hit     (wall_hit),
        .pos_x        (pos_x),
        .pos_y        (pos_y),
        .vel_x        (vel_x),
        .vel_y        (vel_y)
    );

    // only vel_x matters for contact, vel_y feeds the landing rule
    contact_detector u_contact (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .vel_x     (vel_x),
        .on_ground (on_ground),
        .wall_hit  (wall_hit)
    );

endmodule

`default_nettype wire

//--- logic/contact_detector.sv
`timescale 1ns/10ps
`default_nettype none

module contact_detector (
    input  wire                  sys_clk,
    input  wire                  sys_rst_n,
    input  wire character_pkg::phys_t pos_x,
    input  wire character_pkg::phys_t pos_y,
    input  wire character_pkg::phys_t vel_x,
    output logic                 on_ground,
    output logic                 wall_hit
);

    import character_pkg::*;

    logic at_wall;    // touching a wall and still moving into it
    logic wall_seen;  // at_wall of the previous cycle

    // ------------------------------------------------------------------
    // contact tests
    // ------------------------------------------------------------------

    // the low-x wall only counts with vel_x negative, the high-x wall
    // only with vel_x positive, so walking into a wall never bounces
    assign at_wall = (pos_x == MIN_POS_X && vel_x < 0) ||
                     (pos_x == MAX_POS_X && vel_x > 0);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            on_ground <= 1'b0;
        end else begin
            on_ground <= (pos_y == FLOOR_Y);
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wall_seen <= 1'b0;
            wall_hit  <= 1'b0;
        end else begin
            wall_seen <= at_wall;
            wall_hit  <= at_wall && !wall_seen;  // first cycle of an arrival
        end
    end

    // one pulse per arrival at a wall
    a_hit_pulse : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        wall_hit |=> !wall_hit);

endmodule

`default_nettype wire

//--- logic/motion_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module motion_fsm (
    input  wire                   sys_clk,
    input  wire                   sys_rst_n,
    input  wire                   step_tick,
    input  wire                   left_held,
    input  wire                   right_held,
    input  wire                   jump_held,
    input  wire                   jump_request,
    input  wire                   on_ground,
    input  wire                   wall_hit,
    output character_pkg::motion_state_t motion_state,
    output character_pkg::face_t  face,
    output character_pkg::charge_t charge
);

    import character_pkg::*;

    motion_state_t next_state;
    logic          flip_pend;   // wall hit seen since the last tick
    logic          charge_full;

    assign charge_full = (charge >= MAX_CHARGE);

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------

    always_comb begin
        next_state = IDLE;
        case (motion_state)
            IDLE, LEFT, RIGHT: begin
                if (on_ground) begin
                    if (left_held) begin
                        next_state = LEFT;
                    end else if (right_held) begin
                        next_state = RIGHT;
                    end else if (jump_request) begin
                        next_state = CHARGE;
                    end
                end
            end
            CHARGE: begin
                // launch on release or once the charge is full
                if (!jump_held || charge_full) begin
                    next_state = JUMP;
                end else begin
                    next_state = CHARGE;
                end
            end
            default: next_state = IDLE;  // JUMP lasts one tick
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            motion_state <= IDLE;
        end else if (step_tick) begin
            motion_state <= next_state;
        end
    end

    // ------------------------------------------------------------------
    // charge counter and face
    // ------------------------------------------------------------------

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            charge <= 16'd1;
        end else if (step_tick) begin
            if (motion_state == CHARGE && !charge_full) begin
                charge <= charge + CHARGE_STEP;
            end else if (motion_state == JUMP) begin
                charge <= 16'd1;  // physics has taken the launch value
            end
        end
    end

    // wall_hit arrives between ticks, hold it for the next one
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            flip_pend <= 1'b0;
        end else if (step_tick) begin
            flip_pend <= 1'b0;
        end else if (wall_hit) begin
            flip_pend <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            face <= 2'sb01;
        end else if (step_tick) begin
            if (flip_pend || wall_hit) begin
                face <= -face;  // bounced, now looking away from the wall
            end else if (motion_state == LEFT) begin
                face <= 2'sb01;
            end else if (motion_state == RIGHT) begin
                face <= 2'sb11;
            end
        end
    end

    // saturation stops the count one step past the limit at most
    a_charge_bound : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        step_tick |=> charge <= MAX_CHARGE + CHARGE_STEP);

    a_state_legal : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        step_tick |=> motion_state inside {IDLE, LEFT, RIGHT, CHARGE, JUMP});

endmodule

`default_nettype wire

//--- logic/physics_integrator.sv
`timescale 1ns/10ps
`default_nettype none

module physics_integrator (
    input  wire                          sys_clk,
    input  wire                          sys_rst_n,
    input  wire                          step_tick,
    input  wire character_pkg::motion_state_t motion_state,
    input  wire character_pkg::face_t    face,
    input  wire character_pkg::charge_t  charge,
    input  wire                          on_ground,
    input  wire                          wall_hit,
    output character_pkg::phys_t         pos_x,
    output character_pkg::phys_t         pos_y,
    output character_pkg::phys_t         vel_x,
    output character_pkg::phys_t         vel_y
);

    import character_pkg::*;

    phys_t launch_f;           // eight times the charge
    phys_t launch_vx;
    phys_t launch_vy;
    phys_t vx_sum, vy_sum;     // before the clamp
    phys_t vx_next, vy_next;
    phys_t walk;
    phys_t px_sum, py_sum;
    phys_t px_next, py_next;
    logic  bounce_pend;

    function automatic phys_t clamp_vel(input phys_t v);
        if (v > MAX_VEL) begin
            return MAX_VEL;
        end else if (v < -MAX_VEL) begin
            return -MAX_VEL;
        end
        return v;
    endfunction

    // ------------------------------------------------------------------
    // velocity update
    // ------------------------------------------------------------------

    always_comb begin
        launch_f  = phys_t'(charge) <<< 3;
        launch_vy = JUMP_BASE_VY + launch_f;
        // 3/8 of the charge bonus goes sideways
        launch_vx = JUMP_BASE_VX + (launch_f >>> 2) + (launch_f >>> 3);

        if (motion_state == JUMP) begin
            vx_sum = (face < 0) ? -launch_vx : launch_vx;
            vy_sum = launch_vy;
        end else if (on_ground && vel_y <= 0) begin
            vx_sum = '0;  // landed or standing
            vy_sum = '0;
        end else if (bounce_pend || wall_hit) begin
            vx_sum = -(vel_x >>> 1);  // reflect with half the speed
            vy_sum = vel_y - GRAVITY;
        end else begin
            vx_sum = vel_x;
            vy_sum = vel_y - GRAVITY;
        end

        vx_next = clamp_vel(vx_sum);
        vy_next = clamp_vel(vy_sum);
    end

    // ------------------------------------------------------------------
    // position update
    // ------------------------------------------------------------------

    always_comb begin
        case (motion_state)
            LEFT:    walk = WALK_STEP;
            RIGHT:   walk = -WALK_STEP;
            default: walk = '0;
        endcase

        px_sum = pos_x + walk + (vx_next >>> SUBPIXEL_SHIFT);
        py_sum = pos_y + (vy_next >>> SUBPIXEL_SHIFT);

        if (px_sum < MIN_POS_X) begin
            px_next = MIN_POS_X;
        end else if (px_sum > MAX_POS_X) begin
            px_next = MAX_POS_X;
        end else begin
            px_next = px_sum;
        end

        py_next = (py_sum < FLOOR_Y) ? FLOOR_Y : py_sum;  // floor stop
    end

    // the wall pulse comes between ticks
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bounce_pend <= 1'b0;
        end else if (step_tick) begin
            bounce_pend <= 1'b0;
        end else if (wall_hit) begin
            bounce_pend <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x <= '0;
            vel_y <= '0;
            pos_x <= START_POS_X;
            pos_y <= START_POS_Y;
        end else if (step_tick) begin
            vel_x <= vx_next;
            vel_y <= vy_next;
            pos_x <= px_next;
            pos_y <= py_next;
        end
    end

    a_pos_bounds : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        step_tick |=> (pos_x >= MIN_POS_X && pos_x <= MAX_POS_X && pos_y >= FLOOR_Y));

    a_vel_bounds : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        step_tick |=> (vel_x >= -MAX_VEL && vel_x <= MAX_VEL &&
                       vel_y >= -MAX_VEL && vel_y <= MAX_VEL));

endmodule

`default_nettype wire

//--- sim/tb_character.sv
`timescale 1ns/10ps
`default_nettype none

module tb_character;

    import character_pkg::*;

    localparam int NUM_ROWS = 18;
    localparam int CLK_NS   = 40;
    localparam int TICK_CYC = 5;  // strobe cycle plus four settle cycles
    localparam int DRIVE_NS = 2;

    logic          sys_clk;
    logic          sys_rst_n;
    logic          step_tick;
    logic          left_btn;
    logic          right_btn;
    logic          jump_btn;
    phys_t         pos_x;
    phys_t         pos_y;
    face_t         face;
    motion_state_t motion_state;
    logic          on_ground;

    // stimulus table, expected columns come from the reference model
    string         row_name   [NUM_ROWS];
    logic          row_left   [NUM_ROWS];
    logic          row_right  [NUM_ROWS];
    logic          row_jump   [NUM_ROWS];
    int            row_ticks  [NUM_ROWS];
    int            exp_x      [NUM_ROWS];
    int            exp_y      [NUM_ROWS];
    int            exp_face   [NUM_ROWS];
    motion_state_t exp_state  [NUM_ROWS];
    logic          exp_ground [NUM_ROWS];
    int            y_trace[$];  // pos_y after every tick of the run

    bit            table_ready;
    int            rows_added;
    int            total_ticks;
    int            trace_pos;
    int            row_errors;
    int            check_errors;
    int            rows_passed;
    int            rows_failed;

    // reference model state
    int            m_px;
    int            m_py;
    int            m_vx;
    int            m_vy;
    int            m_charge;
    int            m_face;
    motion_state_t m_state;
    logic          m_ground;
    logic          m_req;       // sticky jump request
    logic          m_at_wall;
    logic          m_hit;       // wall pulse seen since the last tick
    logic          m_jump_prev;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clk (.sys_clk(sys_clk));

    character_top uut (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .step_tick    (step_tick),
        .left_btn     (left_btn),
        .right_btn    (right_btn),
        .jump_btn     (jump_btn),
        .pos_x        (pos_x),
        .pos_y        (pos_y),
        .face         (face),
        .motion_state (motion_state),
        .on_ground    (on_ground)
    );

    // ------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------

    task automatic add_row(input string name, input logic l, input logic r,
                           input logic j, input int ticks);
        row_name[rows_added]  = name;
        row_left[rows_added]  = l;
        row_right[rows_added] = r;
        row_jump[rows_added]  = j;
        row_ticks[rows_added] = ticks;
        rows_added++;
    endtask

    task automatic load_table();
        rows_added = 0;
        add_row("reset",          1'b0, 1'b0, 1'b0, 0);
        add_row("idle",           1'b0, 1'b0, 1'b0, 2);
        add_row("walk_left",      1'b1, 1'b0, 1'b0, 10);
        add_row("walk_right",     1'b0, 1'b1, 1'b0, 10);
        add_row("right_to_wall",  1'b0, 1'b1, 1'b0, 40);  // ends clamped at the low wall
        add_row("stop_at_wall",   1'b0, 1'b0, 1'b0, 2);
        add_row("walk_away",      1'b1, 1'b0, 1'b0, 20);
        add_row("stop",           1'b0, 1'b0, 1'b0, 1);
        add_row("jump_press",     1'b0, 1'b0, 1'b1, 1);
        add_row("jump_release",   1'b0, 1'b0, 1'b0, 1);
        add_row("short_arc",      1'b0, 1'b0, 1'b0, 16);
        add_row("charge_full",    1'b0, 1'b0, 1'b1, 60);  // saturates, launches mid row
        add_row("charged_arc",    1'b0, 1'b0, 1'b0, 24);
        add_row("walk_to_wall",   1'b1, 1'b0, 1'b0, 45);
        add_row("stop_near_wall", 1'b0, 1'b0, 1'b0, 1);
        add_row("wall_charge",    1'b0, 1'b0, 1'b1, 20);
        add_row("wall_release",   1'b0, 1'b0, 1'b0, 1);
        add_row("wall_bounce",    1'b0, 1'b0, 1'b0, 24);  // hits the high wall in the air
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------

    function automatic int clamp_int(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    task automatic reset_model();
        m_px        = START_POS_X;
        m_py        = START_POS_Y;
        m_vx        = 0;
        m_vy        = 0;
        m_charge    = 1;
        m_face      = 1;
        m_state     = IDLE;
        m_ground    = 1'b1;
        m_req       = 1'b0;
        m_at_wall   = 1'b0;
        m_hit       = 1'b0;
        m_jump_prev = 1'b0;
    endtask

    // new button levels at the start of a row
    task automatic latch_buttons(input logic j);
        if (m_state == JUMP) begin
            m_req = 1'b0;
        end else if (j && !m_jump_prev && m_ground) begin
            m_req = 1'b1;  // press edge while standing
        end
        m_jump_prev = j;
    endtask

    task automatic advance_model(input logic l, input logic r, input logic j);
        motion_state_t ns;
        int            boost;
        int            lvx;
        int            nvx;
        int            nvy;
        int            walk;
        logic          at_wall;

        ns = IDLE;
        case (m_state)
            IDLE, LEFT, RIGHT: begin
                if (m_ground && l) begin
                    ns = LEFT;
                end else if (m_ground && r) begin
                    ns = RIGHT;
                end else if (m_ground && m_req) begin
                    ns = CHARGE;
                end
            end
            CHARGE: ns = (!j || m_charge >= int'(MAX_CHARGE)) ? JUMP : CHARGE;
            default: ns = IDLE;
        endcase

        if (m_state == JUMP) begin
            boost = 8 * m_charge;
            lvx   = int'(JUMP_BASE_VX) + (3 * boost) / 8;
            nvx   = (m_face < 0) ? -lvx : lvx;
            nvy   = int'(JUMP_BASE_VY) + boost;
        end else if (m_ground && m_vy <= 0) begin
            nvx = 0;
            nvy = 0;
        end else if (m_hit) begin
            nvx = -(m_vx >>> 1);  // damped reflection
            nvy = m_vy - int'(GRAVITY);
        end else begin
            nvx = m_vx;
            nvy = m_vy - int'(GRAVITY);
        end
        nvx = clamp_int(nvx, -int'(MAX_VEL), int'(MAX_VEL));
        nvy = clamp_int(nvy, -int'(MAX_VEL), int'(MAX_VEL));

        walk = (m_state == LEFT) ? int'(WALK_STEP) : (m_state == RIGHT) ? -int'(WALK_STEP) : 0;
        m_px = clamp_int(m_px + walk + (nvx >>> SUBPIXEL_SHIFT), MIN_POS_X, MAX_POS_X);
        m_py = m_py + (nvy >>> SUBPIXEL_SHIFT);
        if (m_py < int'(FLOOR_Y)) begin
            m_py = FLOOR_Y;
        end
        m_vx = nvx;
        m_vy = nvy;

        if (m_hit) begin
            m_face = -m_face;
        end else if (m_state == LEFT) begin
            m_face = 1;
        end else if (m_state == RIGHT) begin
            m_face = -1;
        end

        if (m_state == CHARGE && m_charge < int'(MAX_CHARGE)) begin
            m_charge = m_charge + int'(CHARGE_STEP);
        end else if (m_state == JUMP) begin
            m_charge = 1;
        end
        m_state = ns;

        // contact seen between this tick and the next
        m_ground  = (m_py == int'(FLOOR_Y));
        at_wall   = (m_px == int'(MIN_POS_X) && m_vx < 0) || (m_px == int'(MAX_POS_X) && m_vx > 0);
        m_hit     = at_wall && !m_at_wall;
        m_at_wall = at_wall;
        if (m_state == JUMP) begin
            m_req = 1'b0;
        end
    endtask

    task automatic fill_expected();
        reset_model();
        total_ticks = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            latch_buttons(row_jump[i]);
            for (int t = 0; t < row_ticks[i]; t++) begin
                advance_model(row_left[i], row_right[i], row_jump[i]);
                y_trace.push_back(m_py);
            end
            total_ticks   += row_ticks[i];
            exp_x[i]      = m_px;
            exp_y[i]      = m_py;
            exp_face[i]   = m_face;
            exp_state[i]  = m_state;
            exp_ground[i] = m_ground;
        end
    endtask

    // ------------------------------------------------------------------
    // DUT drive and checks
    // ------------------------------------------------------------------

    task automatic issue_tick();
        step_tick = 1'b1;
        @(posedge sys_clk);
        #DRIVE_NS;
        step_tick = 1'b0;
        repeat (TICK_CYC - 1) @(posedge sys_clk);  // contact flags settle
        #DRIVE_NS;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic run_row(input int i);
        row_errors = 0;
        left_btn   = row_left[i];
        right_btn  = row_right[i];
        jump_btn   = row_jump[i];
        repeat (2) @(posedge sys_clk);  // button registers and request
        #DRIVE_NS;
        for (int t = 0; t < row_ticks[i]; t++) begin
            issue_tick();
            check_value(row_name[i], $sformatf("pos_y at tick %0d", t + 1),
                        y_trace[trace_pos], pos_y);
            trace_pos++;
        end
        check_value(row_name[i], "pos_x", exp_x[i], pos_x);
        check_value(row_name[i], "pos_y", exp_y[i], pos_y);
        check_value(row_name[i], "face", exp_face[i], face);
        check_value(row_name[i], "motion_state", exp_state[i], motion_state);
        check_value(row_name[i], "on_ground", exp_ground[i], on_ground);
        if (row_errors == 0) begin
            $display("ok    %-15s x=%0d y=%0d", row_name[i], pos_x, pos_y);
            rows_passed++;
        end else begin
            $display("FAIL  %-15s %0d mismatches", row_name[i], row_errors);
            rows_failed++;
        end
        check_errors += row_errors;
    endtask

    initial begin
        sys_rst_n    = 1'b0;
        step_tick    = 1'b0;
        left_btn     = 1'b0;
        right_btn    = 1'b0;
        jump_btn     = 1'b0;
        trace_pos    = 0;
        check_errors = 0;
        rows_passed  = 0;
        rows_failed  = 0;
        load_table();
        fill_expected();
        table_ready = 1'b1;

        repeat (4) @(posedge sys_clk);
        #DRIVE_NS;
        sys_rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("rows %0d, passed %0d, failed %0d, mismatches %0d",
                 NUM_ROWS, rows_passed, rows_failed, check_errors);
        if (check_errors == 0 && rows_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table with room for reset and row setup
    initial begin
        wait (table_ready);
        #((total_ticks * TICK_CYC + NUM_ROWS * 4 + 40) * CLK_NS);
        $display("watchdog: the run did not finish in the time the table needs");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic sys_clk
);

    // free running, first rising edge half a period in
    initial begin
        sys_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        sys_clk = ~sys_clk;
    end

endmodule

`default_nettype wire
